//--- source/md_settings.svh
`ifndef MD_SETTINGS_SVH
`define MD_SETTINGS_SVH

// operand and result width
`define MD_XLEN 32

// multiplier bits consumed per step, two booth digits
`define MD_MUL_BITS_PER_STEP 4

// quotient bits produced per step
`define MD_DIV_BITS_PER_STEP 2

// edges from accept to resp_valid: load, steps, finish
`define MD_MUL_LATENCY (2 + `MD_XLEN / `MD_MUL_BITS_PER_STEP)
`define MD_DIV_LATENCY (2 + `MD_XLEN / `MD_DIV_BITS_PER_STEP)

// zero divisor skips the steps
`define MD_DIV_ZERO_LATENCY 2

`endif

//--- source/md_pkg.sv
`include "md_settings.svh"

package md_pkg;

   // one data word
   typedef logic [`MD_XLEN-1:0] md_word_t;

   typedef enum logic {
      MD_OP_MUL = 1'b0,
      MD_OP_DIV = 1'b1
   } md_op_t;

   // mul: low/high product half, div: quotient/remainder
   typedef enum logic {
      MD_OUT_LO = 1'b0,
      MD_OUT_HI = 1'b1
   } md_out_sel_t;

   // iteration counter, holds up to the divide latency
   typedef logic [$clog2(`MD_DIV_LATENCY + 1)-1:0] md_count_t;

endpackage

//--- source/md_operand_if.sv
`timescale 1ns/1ps

interface md_operand_if;
   import md_pkg::*;

   md_word_t    x;        // multiplicand / dividend
   md_word_t    y;        // multiplier / divisor
   logic        x_signed;
   logic        y_signed;
   md_op_t      op;
   md_out_sel_t out_sel;

   modport producer (
      output x,
      output y,
      output x_signed,
      output y_signed,
      output op,
      output out_sel
   );

   modport consumer (
      input x,
      input y,
      input x_signed,
      input y_signed,
      input op,
      input out_sel
   );

endinterface

//--- source/md_ctrl_if.sv
`timescale 1ns/1ps

interface md_ctrl_if;
   import md_pkg::*;

   logic     load;    // one cycle, first after accept
   logic     step;    // once per iteration
   logic     finish;  // last cycle
   md_word_t result;  // held until next load

   modport sequencer (
      output load,
      output step,
      output finish,
      input  result
   );

   modport datapath (
      input  load,
      input  step,
      input  finish,
      output result
   );

endinterface

//--- source/md_request_stage.sv
`timescale 1ns/1ps

module md_request_stage (
   input  logic                clk,
   input  logic                accept,
   input  md_pkg::md_word_t    req_in_1,
   input  md_pkg::md_word_t    req_in_2,
   input  logic                req_in_1_signed,
   input  logic                req_in_2_signed,
   input  md_pkg::md_op_t      req_op,
   input  md_pkg::md_out_sel_t req_out_sel,
   md_operand_if.producer      operands
);

   // captured at the accept edge and held for the whole operation
   always_ff @(posedge clk) begin
      if (accept) begin
         operands.x        <= req_in_1;
         operands.y        <= req_in_2;
         operands.x_signed <= req_in_1_signed;
         operands.y_signed <= req_in_2_signed;
         operands.op       <= req_op;
         operands.out_sel  <= req_out_sel;
      end
   end

endmodule

//--- source/md_sequencer.sv
`timescale 1ns/1ps
`include "md_settings.svh"

module md_sequencer (
   input  logic             clk,
   input  logic             reset,
   input  logic             req_valid,
   input  md_pkg::md_op_t   req_op,
   output logic             accept,
   output logic             req_ready,
   output logic             resp_valid,
   output md_pkg::md_word_t resp_result,
   md_operand_if.consumer   operands,
   md_ctrl_if.sequencer     mul_ctrl,
   md_ctrl_if.sequencer     div_ctrl,
   input  logic             zero_divisor
);
   import md_pkg::*;

   localparam md_count_t MUL_LAT = md_count_t'(`MD_MUL_LATENCY);
   localparam md_count_t DIV_LAT = md_count_t'(`MD_DIV_LATENCY);
   // first cycle after load, where a zero divisor is already known
   localparam md_count_t ZERO_CHECK =
      md_count_t'(`MD_DIV_LATENCY - `MD_DIV_ZERO_LATENCY + 1);

   md_count_t cnt;
   logic      busy;
   logic      is_mul;
   logic      first;
   logic      zero_exit;
   logic      finish;
   logic      step;

   assign busy      = (cnt != '0);
   assign req_ready = ~busy;
   assign accept    = req_valid & req_ready;

   assign is_mul    = (operands.op == MD_OP_MUL);
   assign first     = busy & (cnt == (is_mul ? MUL_LAT : DIV_LAT));
   assign zero_exit = busy & ~is_mul & zero_divisor & (cnt == ZERO_CHECK);
   assign finish    = busy & ((cnt == md_count_t'(1)) | zero_exit);
   assign step      = busy & ~first & ~finish;

   // strobes go to the datapath that runs
   assign mul_ctrl.load   = first & is_mul;
   assign mul_ctrl.step   = step & is_mul;
   assign mul_ctrl.finish = finish & is_mul;

   assign div_ctrl.load   = first & ~is_mul;
   assign div_ctrl.step   = step & ~is_mul;
   assign div_ctrl.finish = finish & ~is_mul;

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt        <= '0;
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= finish;  // one cycle, with req_ready back high
         if (accept) begin
            cnt <= (req_op == MD_OP_MUL) ? MUL_LAT : DIV_LAT;
         end else if (finish) begin
            cnt <= '0;          // also ends the short divide
         end else if (busy) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   assign resp_result = is_mul ? mul_ctrl.result : div_ctrl.result;

endmodule

//--- source/booth_multiplier.sv
`timescale 1ns/1ps
`include "md_settings.svh"

module booth_multiplier (
   input  logic           clk,
   md_operand_if.consumer operands,
   md_ctrl_if.datapath    ctrl
);
   import md_pkg::*;

   localparam int XLEN   = `MD_XLEN;
   localparam int BITS   = `MD_MUL_BITS_PER_STEP;
   localparam int DIGITS = BITS / 2;
   localparam int PW     = 2 * XLEN + 2;  // accumulator width
   localparam int MW     = XLEN + 2;      // multiplier with sign and guard bit

   logic [PW-1:0] sum_q;
   logic [PW-1:0] carry_q;
   logic [PW-1:0] mcand_q;   // moves left with each step
   logic [MW-1:0] mplr_q;    // moves right with each step
   logic [PW-1:0] step_s;
   logic [PW-1:0] step_c;
   logic [PW-1:0] fin_s;
   logic [PW-1:0] fin_c;
   logic [PW-1:0] product;

   // one booth digit added into sum/carry, negation +1 goes to carry bit 0
   function automatic logic [2*PW-1:0] booth_csa(
      input logic [PW-1:0] s,
      input logic [PW-1:0] c,
      input logic [2:0]    d,
      input logic [PW-1:0] m
   );
      logic [PW-1:0] pp;
      logic [PW-1:0] maj;
      logic          neg;
      case (d)
         3'b001, 3'b010: pp = m;
         3'b011:         pp = m << 1;
         3'b100:         pp = ~(m << 1);
         3'b101, 3'b110: pp = ~m;
         default:        pp = '0;
      endcase
      neg = d[2] & ~(d[1] & d[0]);
      maj = (s & c) | (c & pp) | (s & pp);
      return {s ^ c ^ pp, maj[PW-2:0], neg};
   endfunction

   always_comb begin
      step_s = sum_q;
      step_c = carry_q;
      for (int i = 0; i < DIGITS; i++) begin
         {step_s, step_c} = booth_csa(step_s, step_c, mplr_q[2*i +: 3], mcand_q << (2*i));
      end
   end

   // leftover digit: +x*2^32 for an unsigned multiplier with msb set, else zero
   assign {fin_s, fin_c} = booth_csa(sum_q, carry_q, mplr_q[2:0], mcand_q);
   assign product = fin_s + fin_c;

   always_ff @(posedge clk) begin
      if (ctrl.load) begin
         sum_q   <= '0;
         carry_q <= '0;
         mcand_q <= {{(PW-XLEN){operands.x_signed & operands.x[XLEN-1]}}, operands.x};
         mplr_q  <= {operands.y_signed & operands.y[XLEN-1], operands.y, 1'b0};
      end else if (ctrl.step) begin
         sum_q   <= step_s;
         carry_q <= step_c;
         mcand_q <= mcand_q << BITS;
         mplr_q  <= {{BITS{mplr_q[MW-1]}}, mplr_q[MW-1:BITS]};
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.finish) begin
         ctrl.result <= (operands.out_sel == MD_OUT_HI) ? product[2*XLEN-1:XLEN]
                                                        : product[XLEN-1:0];
      end
   end

endmodule

//--- source/radix4_divider.sv
`timescale 1ns/1ps
`include "md_settings.svh"

module radix4_divider (
   input  logic           clk,
   md_operand_if.consumer operands,
   md_ctrl_if.datapath    ctrl,
   output logic           zero_divisor
);
   import md_pkg::*;

   localparam int XLEN   = `MD_XLEN;
   localparam int STAGES = `MD_DIV_BITS_PER_STEP;

   md_word_t        dvsr_q;
   md_word_t        rem_q;     // partial remainder
   md_word_t        quo_q;     // dividend bits out at the top, quotient bits in below
   logic            q_neg_q;
   logic            r_neg_q;
   logic            x_neg;
   logic            y_neg;
   md_word_t        x_mag;
   md_word_t        y_mag;
   logic [XLEN:0]   stage_out;
   md_word_t        rem_next;
   md_word_t        quo_next;
   md_word_t        quo_fix;
   md_word_t        rem_fix;

   // shift in one dividend bit, subtract, keep the old value on borrow
   function automatic logic [XLEN:0] restore_stage(
      input md_word_t r,
      input logic     b,
      input md_word_t d
   );
      logic [XLEN+1:0] trial;
      trial = {1'b0, r, b} - {2'b00, d};
      if (trial[XLEN+1]) begin
         return {1'b0, r[XLEN-2:0], b};
      end else begin
         return {1'b1, trial[XLEN-1:0]};
      end
   endfunction

   assign x_neg = operands.x_signed & operands.x[XLEN-1];
   assign y_neg = operands.y_signed & operands.y[XLEN-1];
   assign x_mag = x_neg ? ~operands.x + 1'b1 : operands.x;
   assign y_mag = y_neg ? ~operands.y + 1'b1 : operands.y;

   always_comb begin
      rem_next  = rem_q;
      quo_next  = quo_q;
      stage_out = '0;
      for (int i = 0; i < STAGES; i++) begin
         stage_out = restore_stage(rem_next, quo_next[XLEN-1], dvsr_q);
         rem_next  = stage_out[XLEN-1:0];
         quo_next  = {quo_next[XLEN-2:0], stage_out[XLEN]};
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.load) begin
         rem_q        <= '0;
         quo_q        <= x_mag;
         dvsr_q       <= y_mag;
         q_neg_q      <= x_neg ^ y_neg;
         r_neg_q      <= x_neg;                // remainder follows the dividend
         zero_divisor <= (operands.y == '0);
      end else if (ctrl.step) begin
         rem_q <= rem_next;
         quo_q <= quo_next;
      end
   end

   // -2^31 / -1 comes out of the magnitude path as 0x80000000, rem 0
   assign quo_fix = q_neg_q ? ~quo_q + 1'b1 : quo_q;
   assign rem_fix = r_neg_q ? ~rem_q + 1'b1 : rem_q;

   always_ff @(posedge clk) begin
      if (ctrl.finish) begin
         if (zero_divisor) begin
            ctrl.result <= (operands.out_sel == MD_OUT_HI) ? operands.x : '1;
         end else begin
            ctrl.result <= (operands.out_sel == MD_OUT_HI) ? rem_fix : quo_fix;
         end
      end
   end

endmodule

//--- source/vscale_mul_div.sv
`timescale 1ns/1ps

module vscale_mul_div (
   input  logic                clk,
   input  logic                reset,
   input  logic                req_valid,
   output logic                req_ready,
   input  logic                req_in_1_signed,
   input  logic                req_in_2_signed,
   input  md_pkg::md_op_t      req_op,
   input  md_pkg::md_out_sel_t req_out_sel,
   input  md_pkg::md_word_t    req_in_1,
   input  md_pkg::md_word_t    req_in_2,
   output logic                resp_valid,
   output md_pkg::md_word_t    resp_result
);

   logic accept;
   logic zero_divisor;

   md_operand_if operands ();
   md_ctrl_if    mul_ctrl ();
   md_ctrl_if    div_ctrl ();

   md_request_stage u_request_stage (
      .clk             (clk),
      .accept          (accept),
      .req_in_1        (req_in_1),
      .req_in_2        (req_in_2),
      .req_in_1_signed (req_in_1_signed),
      .req_in_2_signed (req_in_2_signed),
      .req_op          (req_op),
      .req_out_sel     (req_out_sel),
      .operands        (operands.producer)
   );

   md_sequencer u_sequencer (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_op       (req_op),
      .accept       (accept),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_result  (resp_result),
      .operands     (operands.consumer),
      .mul_ctrl     (mul_ctrl.sequencer),
      .div_ctrl     (div_ctrl.sequencer),
      .zero_divisor (zero_divisor)
   );

   booth_multiplier u_booth_multiplier (
      .clk      (clk),
      .operands (operands.consumer),
      .ctrl     (mul_ctrl.datapath)
   );

   radix4_divider u_radix4_divider (
      .clk          (clk),
      .operands     (operands.consumer),
      .ctrl         (div_ctrl.datapath),
      .zero_divisor (zero_divisor)
   );

endmodule

//--- tb/tb_vscale_mul_div.sv
`timescale 1ns/1ps
`include "md_settings.svh"

module tb_vscale_mul_div;
   import md_pkg::*;

   localparam int N_RAND     = 6;
   localparam int WAIT_LIMIT = `MD_DIV_LATENCY + 4;
   // mul and div matrices, zero divisors, busy test, back-to-back run
   localparam int PLANNED_REQS    = 2 * 8 * (25 + N_RAND) + 8 * 5 + 2 + 2 + 16;
   localparam int WATCHDOG_CYCLES = PLANNED_REQS * (`MD_DIV_LATENCY + 4) + 200;

   logic        clk;
   logic        reset;
   logic        req_valid;
   logic        req_in_1_signed;
   logic        req_in_2_signed;
   md_op_t      req_op;
   md_out_sel_t req_out_sel;
   md_word_t    req_in_1;
   md_word_t    req_in_2;
   logic        req_ready;
   logic        resp_valid;
   md_word_t    resp_result;

   logic        m_busy;   // expected ~req_ready
   logic        m_resp;   // expected resp_valid
   logic        m_hold;   // result must still be held
   int          left;
   md_word_t    exp_res;

   integer      seed = 60568;
   int          errors = 0;
   int          n_req = 0;
   int          n_tests = 0;
   int          req_mark = 0;
   int          err_mark = 0;
   md_word_t    corners [5] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};

   vscale_mul_div u_vscale_mul_div (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_in_1_signed (req_in_1_signed),
      .req_in_2_signed (req_in_2_signed),
      .req_op          (req_op),
      .req_out_sel     (req_out_sel),
      .req_in_1        (req_in_1),
      .req_in_2        (req_in_2),
      .resp_valid      (resp_valid),
      .resp_result     (resp_result)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int ref_latency(input md_op_t op, input md_word_t b);
      if (op == MD_OP_MUL) begin
         return `MD_MUL_LATENCY;
      end
      return (b == '0) ? `MD_DIV_ZERO_LATENCY : `MD_DIV_LATENCY;
   endfunction

   function automatic md_word_t ref_result(input md_op_t op, input md_out_sel_t sel,
                                           input logic sa, input logic sb,
                                           input md_word_t a, input md_word_t b);
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] prod;
      logic        na;
      logic        nb;
      md_word_t    ma;
      md_word_t    mb;
      md_word_t    q;
      md_word_t    r;
      ea   = sa ? {{32{a[31]}}, a} : {32'h0, a};
      eb   = sb ? {{32{b[31]}}, b} : {32'h0, b};
      prod = ea * eb;  // mod 2^64 is exact for the 64-bit product
      na   = sa & a[31];
      nb   = sb & b[31];
      ma   = na ? -a : a;
      mb   = nb ? -b : b;
      if (b == '0) begin
         q = '1;
         r = a;
      end else if (sa && sb && a == 32'h80000000 && b == 32'hffffffff) begin
         q = a;  // signed overflow
         r = '0;
      end else begin
         q = ma / mb;
         r = ma % mb;
         if (na ^ nb) begin
            q = -q;
         end
         if (na) begin
            r = -r;
         end
      end
      if (op == MD_OP_MUL) begin
         return (sel == MD_OUT_HI) ? prod[63:32] : prod[31:0];
      end
      return (sel == MD_OUT_HI) ? r : q;
   endfunction

   // expected timing updated from the driven inputs
   always @(posedge clk) begin
      m_resp  <= 1'b0;
      if (reset) begin
         m_busy <= 1'b0;
         m_hold <= 1'b0;
         left   <= 0;
      end else if (req_valid && !m_busy) begin
         m_busy  <= 1'b1;
         m_hold  <= 1'b0;
         left    <= ref_latency(req_op, req_in_2);
         exp_res <= ref_result(req_op, req_out_sel, req_in_1_signed, req_in_2_signed,
                               req_in_1, req_in_2);
      end else if (m_busy) begin
         if (left == 1) begin
            m_busy <= 1'b0;
            m_resp <= 1'b1;
         end
         left <= left - 1;
      end else if (m_resp) begin
         m_hold <= 1'b1;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
      errors++;
   endtask

   a_ready: assert property (@(posedge clk) disable iff (reset) req_ready == !m_busy)
      else report_mismatch("req_ready", !$sampled(m_busy), $sampled(req_ready));

   a_latency: assert property (@(posedge clk) disable iff (reset) resp_valid == m_resp)
      else report_mismatch("resp_valid", $sampled(m_resp), $sampled(resp_valid));

   a_result: assert property (@(posedge clk) disable iff (reset)
                              (m_resp || m_hold) |-> resp_result == exp_res)
      else report_mismatch("resp_result", $sampled(exp_res), $sampled(resp_result));

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      idle(5);
      reset = 1'b0;
   endtask

   task automatic send(input md_op_t op, input md_out_sel_t sel, input logic sa,
                       input logic sb, input md_word_t a, input md_word_t b);
      int   waited;
      logic taken;
      waited          = 0;
      taken           = 1'b0;
      req_valid       = 1'b1;
      req_op          = op;
      req_out_sel     = sel;
      req_in_1_signed = sa;
      req_in_2_signed = sb;
      req_in_1        = a;
      req_in_2        = b;
      do begin
         taken = req_ready;  // value seen by the coming edge
         idle(1);
         waited++;
      end while (!taken && waited < WAIT_LIMIT);
      req_valid = 1'b0;
      n_req++;
      if (!taken) begin
         $display("request not accepted within %0d cycles at %0t", WAIT_LIMIT, $time);
         errors++;
      end
   endtask

   task automatic wait_resp();
      int waited;
      waited = 0;
      while (!resp_valid && waited < WAIT_LIMIT) begin
         idle(1);
         waited++;
      end
      if (!resp_valid) begin
         $display("no response within %0d cycles at %0t", WAIT_LIMIT, $time);
         errors++;
      end
   endtask

   task automatic run_one(input md_op_t op, input md_out_sel_t sel, input logic sa,
                          input logic sb, input md_word_t a, input md_word_t b);
      send(op, sel, sa, sb, a, b);
      wait_resp();
   endtask

   // all signedness and output selects with corner pairs then random
   task automatic run_matrix(input md_op_t op);
      md_word_t a;
      md_word_t b;
      for (int c = 0; c < 8; c++) begin
         for (int i = 0; i < 25; i++) begin
            run_one(op, md_out_sel_t'(c[0]), c[1], c[2], corners[i / 5], corners[i % 5]);
         end
         for (int k = 0; k < N_RAND; k++) begin
            a = $random(seed);
            b = $random(seed);
            if (op == MD_OP_DIV && k[0]) begin
               b = b >> (8 + 3 * k);  // smaller divisors give larger quotients
            end
            run_one(op, md_out_sel_t'(c[0]), c[1], c[2], a, b);
         end
      end
   endtask

   task automatic close_test(input string name);
      n_tests++;
      $display("test %-10s requests %0d errors %0d", name, n_req - req_mark, errors - err_mark);
      req_mark = n_req;
      err_mark = errors;
   endtask

   initial begin
      md_word_t a;
      md_word_t b;
      reset           = 1'b1;
      req_valid       = 1'b0;
      req_op          = MD_OP_MUL;
      req_out_sel     = MD_OUT_LO;
      req_in_1_signed = 1'b0;
      req_in_2_signed = 1'b0;
      req_in_1        = '0;
      req_in_2        = '0;
      apply_reset();

      run_matrix(MD_OP_MUL);
      close_test("mul");
      run_matrix(MD_OP_DIV);
      close_test("div");

      for (int c = 0; c < 8; c++) begin
         for (int i = 0; i < 5; i++) begin
            run_one(MD_OP_DIV, md_out_sel_t'(c[0]), c[1], c[2], corners[i], '0);
         end
      end
      run_one(MD_OP_DIV, MD_OUT_LO, 1'b1, 1'b1, 32'h80000000, 32'hffffffff);
      run_one(MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'h80000000, 32'hffffffff);
      close_test("div_special");

      send(MD_OP_MUL, MD_OUT_HI, 1'b1, 1'b0, $random(seed), $random(seed));
      idle(3);
      apply_reset();  // drops the multiply in flight
      send(MD_OP_DIV, MD_OUT_LO, 1'b1, 1'b1, 32'h12345678, 32'h00000321);
      req_valid = 1'b1;  // held while busy and must be ignored
      req_op    = MD_OP_MUL;
      req_in_1  = $random(seed);
      req_in_2  = $random(seed);
      idle(`MD_DIV_LATENCY - 4);
      req_valid = 1'b0;
      wait_resp();
      close_test("busy");

      for (int k = 0; k < 16; k++) begin
         a = $random(seed);
         b = $random(seed);
         run_one(md_op_t'(k[0]), md_out_sel_t'(k[1]), k[2], k[3], a, b >> k);
         if (k % 4 == 3) begin
            idle(k / 4 + 1);  // gap where the result must hold
         end
      end
      close_test("b2b");

      idle(2);
      $display("tests %0d requests %0d errors %0d", n_tests, n_req, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- vscale_mul_div.f
+incdir+source
source/md_pkg.sv
source/md_operand_if.sv
source/md_ctrl_if.sv
source/md_request_stage.sv
source/md_sequencer.sv
source/booth_multiplier.sv
source/radix4_divider.sv
source/vscale_mul_div.sv
tb/tb_vscale_mul_div.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vscale_mul_div \
   -f vscale_mul_div.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > "$LOG" 2>&1 \
   || { cat build.log "$LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$LOG"
grep -q "Simulation failed" "$LOG" \
   && { echo "result: FAIL"; exit 1; } \
   || { echo "result: PASS"; exit 0; }
